//--- rtl/re_isa_pkg.sv
package re_isa_pkg;

    // ----------------------------------------
    // instruction encoding.
    // ----------------------------------------

    localparam int INSTR_WIDTH = 16;
    localparam int OPCODE_WIDTH = 2;
    localparam int FIELD_WIDTH = 8;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        CHAR   = 2'd0,  // compare one character.
        SPLIT  = 2'd1,  // fork into target and pc+1.
        JMP    = 2'd2,
        ACCEPT = 2'd3   // thread reached a match.
    } opcode_e;

    // character view of an instruction.
    typedef struct packed {
        opcode_e                  opcode;
        logic [5:0]               unused;
        logic [FIELD_WIDTH-1:0]   character;
    } char_view_t;

    // jump view, used by JMP and SPLIT.
    typedef struct packed {
        opcode_e                  opcode;
        logic [5:0]               unused;
        logic [FIELD_WIDTH-1:0]   target;
    } jump_view_t;

    typedef union packed {
        char_view_t char_view;
        jump_view_t jump_view;
    } instr_u;

endpackage

//--- rtl/re_cfg_pkg.sv
package re_cfg_pkg;

    // ----------------------------------------
    // default widths of the matcher.
    // ----------------------------------------

    localparam int PC_WIDTH          = 8;
    localparam int CC_ID_BITS        = 1;   // two character channels.
    localparam int CHARACTER_WIDTH   = 8;

    // program memory port.
    localparam int MEMORY_WIDTH      = 16;
    localparam int MEMORY_ADDR_WIDTH = 8;

    // queues of 2**FIFO_COUNT_WIDTH threads.
    localparam int FIFO_COUNT_WIDTH  = 3;

endpackage

//--- rtl/memory_read_iface.sv
`timescale 1ns/1ps

interface memory_read_iface #(
    parameter int MEMORY_ADDR_WIDTH = 8,
    parameter int MEMORY_WIDTH      = 16
);

    logic                         valid;
    logic [MEMORY_ADDR_WIDTH-1:0] addr;
    logic                         ready;  // data is valid in this cycle.
    logic [MEMORY_WIDTH-1:0]      data;

    // requester holds valid and addr until ready.
    modport requester (
        output valid,
        output addr,
        input  ready,
        input  data
    );

    modport memory (
        input  valid,
        input  addr,
        output ready,
        output data
    );

endinterface

//--- rtl/channel_iface.sv
`timescale 1ns/1ps

interface channel_iface #(
    parameter int N = 9
);

    // data holds pc in the upper bits, channel id in the lower bits.
    logic         valid;
    logic         ready;
    logic [N-1:0] data;

    // data stays stable while valid and not ready.
    modport producer (
        output valid,
        output data,
        input  ready
    );

    modport consumer (
        input  valid,
        input  data,
        output ready
    );

endinterface

//--- rtl/arbiter_2_fixed.sv
`timescale 1ns/1ps

module arbiter_2_fixed #(
    parameter int DWIDTH = 8
) (
    input  logic              in_0_valid_i,
    input  logic [DWIDTH-1:0] in_0_data_i,
    output logic              in_0_ready_o,

    input  logic              in_1_valid_i,
    input  logic [DWIDTH-1:0] in_1_data_i,
    output logic              in_1_ready_o,

    output logic              out_valid_o,
    output logic [DWIDTH-1:0] out_data_o,
    input  logic              out_ready_i
);

    logic sel_0;

    // input 0 has priority whenever it is valid.
    assign sel_0 = in_0_valid_i;

    assign out_valid_o = in_0_valid_i | in_1_valid_i;
    assign out_data_o  = sel_0 ? in_0_data_i : in_1_data_i;

    // ----------------------------------------
    // ready only reaches the winner.
    // ----------------------------------------

    assign in_0_ready_o = out_ready_i & sel_0;
    assign in_1_ready_o = out_ready_i & ~sel_0;

endmodule

//--- rtl/regex_engine.sv
`timescale 1ns/1ps

module regex_engine #(
    parameter int PC_WIDTH          = 8,
    parameter int CC_ID_BITS        = 1,
    parameter int CHARACTER_WIDTH   = 8,
    parameter int MEMORY_WIDTH      = 16,
    parameter int MEMORY_ADDR_WIDTH = 8,
    parameter int FIFO_COUNT_WIDTH  = 3
) (
    input  logic                                       clk,
    input  logic                                       rst_i,
    output logic                                       accepts_o,
    output logic                                       running_o,
    output logic                                       full_o,
    output logic [(2**CC_ID_BITS)-1:0]                 elaborating_chars_o,
    input  logic [(2**CC_ID_BITS)-1:0]                 cur_window_end_of_s_i,
    input  logic [(2**CC_ID_BITS)-1:0]                 cur_window_enable_i,
    input  logic [(2**CC_ID_BITS)*CHARACTER_WIDTH-1:0] cur_window_i,
    input  logic                                       new_char_i,
    memory_read_iface.requester                        memory,
    channel_iface.consumer                             in,
    channel_iface.producer                             out
);

    localparam int DEPTH = 2**FIFO_COUNT_WIDTH;
    localparam int TW    = PC_WIDTH + CC_ID_BITS;

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_FETCH  = 2'd1;
    localparam logic [1:0] S_DECODE = 2'd2;
    localparam logic [1:0] S_ISSUE  = 2'd3;  // second push of a SPLIT.

    logic [1:0]                  state;
    logic [PC_WIDTH-1:0]         cur_pc;
    logic [CC_ID_BITS-1:0]       cur_cc;
    logic [PC_WIDTH-1:0]         pc_next;
    re_isa_pkg::instr_u          instr_q;
    re_isa_pkg::opcode_e         opcode;
    logic [MEMORY_WIDTH-1:0]     mem_word;

    logic [TW-1:0]               q_mem [2][DEPTH];
    logic [FIFO_COUNT_WIDTH-1:0] rd_ptr [2];
    logic [FIFO_COUNT_WIDTH-1:0] wr_ptr [2];
    logic [FIFO_COUNT_WIDTH:0]   count [2];
    logic                        cur_sel;  // index of the current queue.
    logic [1:0]                  push;
    logic [1:0]                  pop;
    logic [TW-1:0]               push_data [2];
    logic [TW-1:0]               head;

    logic                        swap_go;
    logic                        in_push;
    logic                        pop_cur;
    logic                        match_push;
    logic                        next_full;
    logic                        char_match;
    logic [CHARACTER_WIDTH-1:0]  thread_char;

    // ----------------------------------------
    // queue control.
    // ----------------------------------------

    assign head      = q_mem[cur_sel][rd_ptr[cur_sel]];
    assign full_o    = count[cur_sel][FIFO_COUNT_WIDTH];
    assign next_full = count[~cur_sel][FIFO_COUNT_WIDTH];

    // swap only once both channels are done with this character.
    assign swap_go  = new_char_i && (elaborating_chars_o == '0);
    assign in.ready = ~full_o & ~swap_go;
    assign in_push  = in.valid & in.ready;
    assign pop_cur  = (state == S_IDLE) && (count[cur_sel] != '0);

    always_comb begin
        for (int q = 0; q < 2; q++) begin
            if (cur_sel == 1'(q)) begin
                push[q]      = in_push;
                push_data[q] = in.data;
                pop[q]       = pop_cur;
            end else begin
                push[q]      = match_push;  // survivors wait for the next character.
                push_data[q] = {pc_next, cur_cc};
                pop[q]       = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cur_sel <= 1'b0;
            for (int q = 0; q < 2; q++) begin
                rd_ptr[q] <= '0;
                wr_ptr[q] <= '0;
                count[q]  <= '0;
            end
        end else begin
            if (swap_go) begin
                cur_sel <= ~cur_sel;
            end
            for (int q = 0; q < 2; q++) begin
                if (push[q]) begin
                    wr_ptr[q] <= wr_ptr[q] + 1'b1;
                end
                if (pop[q]) begin
                    rd_ptr[q] <= rd_ptr[q] + 1'b1;
                end
                count[q] <= count[q] + (FIFO_COUNT_WIDTH+1)'(push[q])
                                     - (FIFO_COUNT_WIDTH+1)'(pop[q]);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int q = 0; q < 2; q++) begin
            if (push[q]) begin
                q_mem[q][wr_ptr[q]] <= push_data[q];
            end
        end
    end

    // channels with work left on the current character.
    always_comb begin
        logic [FIFO_COUNT_WIDTH-1:0] offs;
        elaborating_chars_o = '0;
        for (int i = 0; i < DEPTH; i++) begin
            offs = FIFO_COUNT_WIDTH'(i) - rd_ptr[cur_sel];
            if ({1'b0, offs} < count[cur_sel]) begin
                elaborating_chars_o[q_mem[cur_sel][i][CC_ID_BITS-1:0]] = 1'b1;
            end
        end
        if (state != S_IDLE) begin
            elaborating_chars_o[cur_cc] = 1'b1;
        end
    end

    assign running_o = (count[0] != '0) || (count[1] != '0) || (state != S_IDLE);

    // ----------------------------------------
    // fetch and decode.
    // ----------------------------------------

    assign memory.valid = (state == S_FETCH);
    assign memory.addr  = MEMORY_ADDR_WIDTH'(cur_pc);
    assign mem_word     = memory.data;

    assign opcode  = instr_q.char_view.opcode;
    assign pc_next = cur_pc + 1'b1;

    assign thread_char = cur_window_i[cur_cc*CHARACTER_WIDTH +: CHARACTER_WIDTH];
    assign char_match  = cur_window_enable_i[cur_cc] & ~cur_window_end_of_s_i[cur_cc]
                       & (thread_char == CHARACTER_WIDTH'(instr_q.char_view.character));

    // a full next queue drops the survivor.
    assign match_push = (state == S_DECODE) && (opcode == re_isa_pkg::CHAR)
                      && char_match && !next_full;

    assign accepts_o = (state == S_DECODE) && (opcode == re_isa_pkg::ACCEPT);

    assign out.valid = ((state == S_DECODE) && ((opcode == re_isa_pkg::JMP)
                        || (opcode == re_isa_pkg::SPLIT))) || (state == S_ISSUE);
    assign out.data  = (state == S_ISSUE) ? {pc_next, cur_cc}
                     : {PC_WIDTH'(instr_q.jump_view.target), cur_cc};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (pop_cur) state <= S_FETCH;
                S_FETCH: if (memory.ready) state <= S_DECODE;
                S_DECODE: begin
                    case (opcode)
                        re_isa_pkg::JMP:   if (out.ready) state <= S_IDLE;
                        re_isa_pkg::SPLIT: if (out.ready) state <= S_ISSUE;
                        default:           state <= S_IDLE;
                    endcase
                end
                S_ISSUE: if (out.ready) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop_cur) begin
            {cur_pc, cur_cc} <= head;
        end
        if ((state == S_FETCH) && memory.ready) begin
            instr_q <= mem_word[re_isa_pkg::INSTR_WIDTH-1:0];
        end
    end

endmodule

//--- rtl/topology_single.sv
`timescale 1ns/1ps

module topology_single #(
    parameter int PC_WIDTH          = re_cfg_pkg::PC_WIDTH,
    parameter int CC_ID_BITS        = re_cfg_pkg::CC_ID_BITS,
    parameter int CHARACTER_WIDTH   = re_cfg_pkg::CHARACTER_WIDTH,
    parameter int MEMORY_WIDTH      = re_cfg_pkg::MEMORY_WIDTH,
    parameter int MEMORY_ADDR_WIDTH = re_cfg_pkg::MEMORY_ADDR_WIDTH,
    parameter int FIFO_COUNT_WIDTH  = re_cfg_pkg::FIFO_COUNT_WIDTH
) (
    input  logic                                       clk,
    input  logic                                       rst_i,
    output logic                                       any_bb_accept_o,
    output logic                                       any_bb_running_o,
    output logic                                       all_bb_full_o,
    output logic [(2**CC_ID_BITS)-1:0]                 elaborating_chars_o,
    input  logic [(2**CC_ID_BITS)-1:0]                 cur_window_end_of_s_i,
    input  logic [(2**CC_ID_BITS)-1:0]                 cur_window_enable_i,
    input  logic [(2**CC_ID_BITS)*CHARACTER_WIDTH-1:0] cur_window_i,
    input  logic                                       new_char_i,

    input  logic                                       override_valid_i,
    input  logic [PC_WIDTH+CC_ID_BITS-1:0]             override_data_i,
    output logic                                       override_ready_o,

    input  logic                                       mem_cc_valid_i,
    input  logic [MEMORY_ADDR_WIDTH-1:0]               mem_cc_addr_i,
    output logic                                       mem_cc_ready_o,
    output logic [MEMORY_WIDTH-1:0]                    mem_cc_data_o,

    output logic                                       mem_valid_o,
    output logic [MEMORY_ADDR_WIDTH-1:0]               mem_addr_o,
    input  logic                                       mem_ready_i,
    input  logic [MEMORY_WIDTH-1:0]                    mem_data_i
);

    memory_read_iface #(
        .MEMORY_ADDR_WIDTH (MEMORY_ADDR_WIDTH),
        .MEMORY_WIDTH      (MEMORY_WIDTH)
    ) memory_bb ();

    // 0 feeds the engine, 1 carries its re-issued threads.
    channel_iface #(.N(PC_WIDTH+CC_ID_BITS)) channel_i [1:0] ();

    regex_engine #(
        .PC_WIDTH              (PC_WIDTH),
        .CC_ID_BITS            (CC_ID_BITS),
        .CHARACTER_WIDTH       (CHARACTER_WIDTH),
        .MEMORY_WIDTH          (MEMORY_WIDTH),
        .MEMORY_ADDR_WIDTH     (MEMORY_ADDR_WIDTH),
        .FIFO_COUNT_WIDTH      (FIFO_COUNT_WIDTH)
    ) i_engine (
        .clk                   (clk),
        .rst_i                 (rst_i),
        .accepts_o             (any_bb_accept_o),
        .running_o             (any_bb_running_o),
        .full_o                (all_bb_full_o),
        .elaborating_chars_o   (elaborating_chars_o),
        .cur_window_end_of_s_i (cur_window_end_of_s_i),
        .cur_window_enable_i   (cur_window_enable_i),
        .cur_window_i          (cur_window_i),
        .new_char_i            (new_char_i),
        .memory                (memory_bb.requester),
        .in                    (channel_i[0].consumer),
        .out                   (channel_i[1].producer)
    );

    // ----------------------------------------
    // thread insertion.
    // ----------------------------------------

    arbiter_2_fixed #(
        .DWIDTH (PC_WIDTH+CC_ID_BITS)
    ) i_thread_arbiter (
        .in_0_valid_i (override_valid_i),
        .in_0_data_i  (override_data_i),
        .in_0_ready_o (override_ready_o),
        .in_1_valid_i (channel_i[1].valid),
        .in_1_data_i  (channel_i[1].data),
        .in_1_ready_o (channel_i[1].ready),
        .out_valid_o  (channel_i[0].valid),
        .out_data_o   (channel_i[0].data),
        .out_ready_i  (channel_i[0].ready)
    );

    // ----------------------------------------
    // memory sharing.
    // ----------------------------------------

    arbiter_2_fixed #(
        .DWIDTH (MEMORY_ADDR_WIDTH)
    ) i_memory_arbiter (
        .in_0_valid_i (mem_cc_valid_i),
        .in_0_data_i  (mem_cc_addr_i),
        .in_0_ready_o (mem_cc_ready_o),
        .in_1_valid_i (memory_bb.valid),
        .in_1_data_i  (memory_bb.addr),
        .in_1_ready_o (memory_bb.ready),
        .out_valid_o  (mem_valid_o),
        .out_data_o   (mem_addr_o),
        .out_ready_i  (mem_ready_i)
    );

    // read data goes to both; ready alone tells the winner.
    assign mem_cc_data_o  = mem_data_i;
    assign memory_bb.data = mem_data_i;

endmodule

//--- tests/topology_single_assert.sv
`timescale 1ns/1ps

module topology_single_assert #(
    parameter int TW = re_cfg_pkg::PC_WIDTH + re_cfg_pkg::CC_ID_BITS,
    parameter int AW = re_cfg_pkg::MEMORY_ADDR_WIDTH
) (
    input logic          clk,
    input logic          rst_i,
    input logic          override_valid_i,
    input logic [TW-1:0] override_data_i,
    input logic          override_ready_o,
    input logic          mem_cc_valid_i,
    input logic [AW-1:0] mem_cc_addr_i,
    input logic          mem_cc_ready_o,
    input logic          mem_valid_o,
    input logic          mem_ready_i,
    input logic          any_bb_accept_o
);

    // ----------------------------------------
    // handshakes.
    // ----------------------------------------

    override_hold: assert property (@(posedge clk) disable iff (rst_i)
        override_valid_i && !override_ready_o |=> override_valid_i && $stable(override_data_i))
        else $error("override request dropped or changed before ready");

    cc_hold: assert property (@(posedge clk) disable iff (rst_i)
        mem_cc_valid_i && !mem_cc_ready_o |=> mem_cc_valid_i && $stable(mem_cc_addr_i))
        else $error("cc memory request dropped or changed before ready");

    // the address may switch to the cc, but a request stays up.
    mem_hold: assert property (@(posedge clk) disable iff (rst_i)
        mem_valid_o && !mem_ready_i |=> mem_valid_o)
        else $error("memory request dropped before ready");

    cc_ready_needs_valid: assert property (@(posedge clk) disable iff (rst_i)
        !(mem_cc_ready_o && !mem_cc_valid_i))
        else $error("mem_cc_ready_o high without a cc request");

    accept_single: assert property (@(posedge clk) disable iff (rst_i)
        any_bb_accept_o |=> !any_bb_accept_o)
        else $error("accept pulse longer than one cycle");

endmodule

bind topology_single topology_single_assert #(
    .TW (PC_WIDTH + CC_ID_BITS),
    .AW (MEMORY_ADDR_WIDTH)
) i_assert (
    .clk              (clk),
    .rst_i            (rst_i),
    .override_valid_i (override_valid_i),
    .override_data_i  (override_data_i),
    .override_ready_o (override_ready_o),
    .mem_cc_valid_i   (mem_cc_valid_i),
    .mem_cc_addr_i    (mem_cc_addr_i),
    .mem_cc_ready_o   (mem_cc_ready_o),
    .mem_valid_o      (mem_valid_o),
    .mem_ready_i      (mem_ready_i),
    .any_bb_accept_o  (any_bb_accept_o)
);

//--- tests/tb_topology_single.sv
`timescale 1ns/1ps

module tb_topology_single;

    localparam int PCW     = re_cfg_pkg::PC_WIDTH;
    localparam int CCW     = re_cfg_pkg::CC_ID_BITS;
    localparam int NCH     = 2**CCW;
    localparam int CW      = re_cfg_pkg::CHARACTER_WIDTH;
    localparam int AW      = re_cfg_pkg::MEMORY_ADDR_WIDTH;
    localparam int MW      = re_cfg_pkg::MEMORY_WIDTH;
    localparam int TIMEOUT = 500;
    localparam logic [AW-1:0] CC_ADDR = 8'hC3;

    logic                 clk;
    logic                 rst_i;
    logic                 any_bb_accept_o;
    logic                 any_bb_running_o;
    logic                 all_bb_full_o;
    logic [NCH-1:0]       elaborating_chars_o;
    logic [NCH-1:0]       cur_window_end_of_s_i;
    logic [NCH-1:0]       cur_window_enable_i;
    logic [NCH*CW-1:0]    cur_window_i;
    logic                 new_char_i;
    logic                 override_valid_i;
    logic [PCW+CCW-1:0]   override_data_i;
    logic                 override_ready_o;
    logic                 mem_cc_valid_i;
    logic [AW-1:0]        mem_cc_addr_i;
    logic                 mem_cc_ready_o;
    logic [MW-1:0]        mem_cc_data_o;
    logic                 mem_valid_o;
    logic [AW-1:0]        mem_addr_o;
    logic                 mem_ready_i = 1'b0;
    logic [MW-1:0]        mem_data_i;

    logic [MW-1:0] prog [2**AW];
    logic          req_seen = 1'b0;
    int            wait_left = -1;
    logic [15:0]   lfsr = 16'd24105;
    int            accept_count = 0;
    int            errors = 0;
    int            errors_before = 0;
    int            tests = 0;
    bit            saw_full;
    bit            saw_stall;

    topology_single i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ----------------------------------------
    // program memory model.
    // ----------------------------------------

    assign mem_data_i = prog[mem_addr_o];  // read data follows the winning address.

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int next_delay();
        int d;
        d = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_step(lfsr);
            d = (d << 1) | int'(lfsr[0]);
        end
        return d;
    endfunction

    always @(posedge clk) begin
        req_seen <= mem_valid_o;
        if (!rst_i && any_bb_accept_o) accept_count++;
    end

    always @(negedge clk) begin
        if (mem_ready_i) begin
            mem_ready_i = 1'b0;  // one-cycle answer.
            wait_left   = -1;
        end else if (req_seen) begin
            if (wait_left < 0) wait_left = next_delay();
            if (wait_left == 0) mem_ready_i = 1'b1;
            wait_left = wait_left - 1;
        end
    end

    // ----------------------------------------
    // helpers.
    // ----------------------------------------

    task automatic record_failure(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic record_timeout(input string what);
        $display("timed out while waiting for %s", what);
        errors++;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %-10s finished with %0d error(s)", name, errors - errors_before);
        errors_before = errors;
    endtask

    function automatic logic [MW-1:0] op_char(input logic [7:0] c);
        re_isa_pkg::instr_u u;
        u = '0;
        u.char_view.opcode    = re_isa_pkg::CHAR;
        u.char_view.character = c;
        return u;
    endfunction

    // also used for ACCEPT, whose operand is ignored.
    function automatic logic [MW-1:0] op_jump(input re_isa_pkg::opcode_e op, input logic [7:0] t);
        re_isa_pkg::instr_u u;
        u = '0;
        u.jump_view.opcode = op;
        u.jump_view.target = t;
        return u;
    endfunction

    task automatic clear_program();
        for (int a = 0; a < 2**AW; a++) begin
            prog[a] = {AW'(a) ^ 8'h3C, AW'(a)};
        end
    endtask

    task automatic inject(input logic [PCW-1:0] pc, input logic [CCW-1:0] cc);
        int t;
        bit done;
        t    = 0;
        done = 1'b0;
        override_valid_i = 1'b1;
        override_data_i  = {pc, cc};
        while (!done && t < TIMEOUT) begin
            @(posedge clk);
            t++;
            if (all_bb_full_o) saw_full = 1'b1;
            if (override_ready_o) done = 1'b1;
            else saw_stall = 1'b1;
        end
        @(negedge clk);
        override_valid_i = 1'b0;
        if (!done) record_timeout("override_ready_o");
    endtask

    // whole waits for running low, otherwise for the masked channels to clear.
    task automatic wait_quiet(input logic [NCH-1:0] mask, input bit whole);
        int t;
        t = 0;
        while ((whole ? any_bb_running_o : |(elaborating_chars_o & mask)) && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (whole ? any_bb_running_o : |(elaborating_chars_o & mask)) begin
            record_timeout(whole ? "the engine to stop" : "elaborating_chars_o to clear");
        end
    endtask

    task automatic step_char(input logic [7:0] c0, input logic [7:0] c1);
        cur_window_i = {c1, c0};
        new_char_i   = 1'b1;
        @(negedge clk);
        new_char_i   = 1'b0;
        wait_quiet('1, 1'b0);
    endtask

    task automatic feed_three(input logic [7:0] c0, input logic [7:0] c1, input logic [7:0] c2);
        cur_window_i        = {8'h00, c0};
        cur_window_enable_i = 2'b01;
        inject(PCW'(0), CCW'(0));
        wait_quiet('1, 1'b0);
        step_char(c1, 8'h00);
        step_char(c2, 8'h00);
        wait_quiet('1, 1'b1);
    endtask

    // ----------------------------------------
    // directed tests.
    // ----------------------------------------

    task automatic test_reset();
        assert (!any_bb_accept_o && !any_bb_running_o && !all_bb_full_o)
            else record_failure("status outputs not low after reset");
        assert (elaborating_chars_o == '0) else record_failure("elaborating_chars_o set");
        assert (!mem_valid_o) else record_failure("mem_valid_o high after reset");
        assert (!override_ready_o && !mem_cc_ready_o) else record_failure("ready high after reset");
        finish_test("reset");
    endtask

    task automatic test_literal();
        int start;
        clear_program();
        prog[0] = op_char("a");
        prog[1] = op_char("b");
        prog[2] = op_jump(re_isa_pkg::ACCEPT, 8'd0);
        start = accept_count;
        feed_three("a", "b", "-");
        assert (accept_count - start == 1)
            else record_failure($sformatf("ab gave %0d accepts", accept_count - start));
        start = accept_count;
        feed_three("a", "c", "-");
        assert (accept_count == start) else record_failure("ac gave an accept");
        assert (!any_bb_running_o) else record_failure("running stays high after ac");
        finish_test("literal");
    endtask

    task automatic test_split();
        logic [7:0] chars [3];
        int         expect_n [3];
        int         start;
        chars    = '{"x", "y", "z"};
        expect_n = '{1, 1, 0};
        clear_program();
        prog[0] = op_jump(re_isa_pkg::SPLIT, 8'd3);
        prog[1] = op_char("x");
        prog[2] = op_jump(re_isa_pkg::JMP, 8'd5);
        prog[3] = op_char("y");
        prog[4] = op_jump(re_isa_pkg::JMP, 8'd5);
        prog[5] = op_jump(re_isa_pkg::ACCEPT, 8'd0);
        for (int i = 0; i < 3; i++) begin
            start = accept_count;
            feed_three(chars[i], "-", "-");
            assert (accept_count - start == expect_n[i]) else record_failure(
                $sformatf("split on %c gave %0d accepts", chars[i], accept_count - start));
        end
        finish_test("split");
    endtask

    task automatic test_channels();
        int start;
        clear_program();
        prog[0] = op_char("a");
        prog[1] = op_jump(re_isa_pkg::ACCEPT, 8'd0);
        start = accept_count;
        cur_window_i        = {8'("b"), 8'("a")};
        cur_window_enable_i = 2'b11;
        inject(PCW'(0), CCW'(0));
        inject(PCW'(0), CCW'(1));
        assert (elaborating_chars_o[1]) else record_failure("channel 1 not elaborating");
        wait_quiet(2'b10, 1'b0);
        wait_quiet('1, 1'b0);
        step_char("-", "-");
        wait_quiet('1, 1'b1);
        assert (accept_count - start == 1)
            else record_failure($sformatf("two channels gave %0d accepts", accept_count - start));
        finish_test("channels");
    endtask

    task automatic test_memory();
        int t;
        int start;
        bit served;
        clear_program();
        prog[0] = op_jump(re_isa_pkg::ACCEPT, 8'd0);
        start = accept_count;
        inject(PCW'(0), CCW'(0));
        t = 0;
        while (!mem_valid_o && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!mem_valid_o) record_timeout("the engine fetch");
        mem_cc_valid_i = 1'b1;
        mem_cc_addr_i  = CC_ADDR;
        t      = 0;
        served = 1'b0;
        while (!served && t < TIMEOUT) begin
            @(posedge clk);
            t++;
            assert (mem_addr_o == CC_ADDR) else record_failure("engine address won over cc");
            if (mem_cc_ready_o) begin
                served = 1'b1;
                assert (mem_cc_data_o == prog[CC_ADDR]) else record_failure("wrong cc read data");
            end
        end
        @(negedge clk);
        mem_cc_valid_i = 1'b0;
        if (!served) record_timeout("mem_cc_ready_o");
        wait_quiet('1, 1'b1);
        assert (accept_count - start == 1) else record_failure("engine fetch lost after cc read");
        finish_test("memory");
    endtask

    task automatic test_backpressure();
        int start;
        clear_program();
        prog[0] = op_jump(re_isa_pkg::ACCEPT, 8'd0);
        start     = accept_count;
        saw_full  = 1'b0;
        saw_stall = 1'b0;
        for (int i = 0; i < 16; i++) begin
            inject(PCW'(0), CCW'(0));
        end
        wait_quiet('1, 1'b1);
        assert (saw_full) else record_failure("all_bb_full_o never rose");
        assert (saw_stall) else record_failure("override_ready_o never fell");
        assert (accept_count - start == 16)
            else record_failure($sformatf("16 threads gave %0d accepts", accept_count - start));
        finish_test("backpress");
    endtask

    initial begin
        rst_i                 = 1'b1;
        new_char_i            = 1'b0;
        override_valid_i      = 1'b0;
        override_data_i       = '0;
        mem_cc_valid_i        = 1'b0;
        mem_cc_addr_i         = '0;
        cur_window_end_of_s_i = '0;
        cur_window_enable_i   = '0;
        cur_window_i          = '0;
        clear_program();
        repeat (3) @(negedge clk);
        rst_i = 1'b0;
        test_reset();
        test_literal();
        test_split();
        test_channels();
        test_memory();
        test_backpressure();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/re_isa_pkg.sv
rtl/re_cfg_pkg.sv
rtl/memory_read_iface.sv
rtl/channel_iface.sv
rtl/arbiter_2_fixed.sv
rtl/regex_engine.sv
rtl/topology_single.sv
tests/topology_single_assert.sv
tests/tb_topology_single.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_topology_single -o tb_topology_single

./obj_dir/tb_topology_single | tee sim.log

if grep -qx "Simulation completed successfully" sim.log; then
    echo "run.sh: pass"
else
    echo "run.sh: fail"
    exit 1
fi
